//--- hw/cpu_pkg.sv
package cpu_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0] reg_addr_t;
  typedef logic [31:0] instr_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Encodings
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef enum logic [6:0] {
    op_lui    = 7'b0110111,
    op_jal    = 7'b1101111,
    op_jalr   = 7'b1100111,
    op_branch = 7'b1100011,
    op_load   = 7'b0000011,
    op_store  = 7'b0100011,
    op_imm    = 7'b0010011,
    op_reg    = 7'b0110011
  } opcode_t;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt,
    alu_sltu, alu_sll, alu_srl, alu_sra, alu_pass_b
  } alu_op_t;

  typedef enum logic [3:0] {
    br_none, br_beq, br_bne, br_blt, br_bge,
    br_bltu, br_bgeu, br_jal, br_jalr
  } branch_op_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Memory ports
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef struct packed {
    logic mem_valid;
    logic mem_instr;                 // Set on instruction fetches
    word_t mem_addr;
    word_t mem_wdata;
    logic mem_write;
  } mem_in_type;

  typedef struct packed {
    logic mem_ready;
    word_t mem_rdata;
  } mem_out_type;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Units and stages
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef struct packed {
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    word_t imm;
    alu_op_t alu_op;
    branch_op_t branch_op;
    logic use_imm;
    logic use_pc;                    // ALU computes pc + 4 for the link value
    logic load;
    logic store;
    logic write_rd;
  } decoder_out_type;

  typedef struct packed {
    word_t a;
    word_t b;
    alu_op_t op;
  } alu_in_type;

  typedef struct packed {
    word_t result;
  } alu_out_type;

  typedef struct packed {
    word_t a;
    word_t b;
    word_t pc;
    word_t imm;
    branch_op_t branch_op;
  } bcu_in_type;

  typedef struct packed {
    logic taken;
    word_t target;
  } bcu_out_type;

  typedef struct packed {
    logic valid;
    word_t pc;
    instr_t instr;
  } fetch_out_type;

  typedef struct packed {
    logic valid;
    word_t result;                   // ALU result or memory address
    word_t store_data;
    reg_addr_t rd;
    logic write_rd;
    logic load;
    logic store;
  } execute_out_type;

  typedef struct packed {
    logic valid;
    word_t target;
  } redirect_type;

  typedef struct packed {
    logic valid;
    reg_addr_t rd;
    word_t value;
  } memory_fwd_type;

endpackage

//--- hw/decoder.sv
module decoder (
  input cpu_pkg::instr_t instr,
  output cpu_pkg::decoder_out_type decoder_out
);

  cpu_pkg::opcode_t opcode;
  logic [2:0] funct3;

  assign opcode = cpu_pkg::opcode_t'(instr[6:0]);
  assign funct3 = instr[14:12];

  function automatic cpu_pkg::alu_op_t alu_from_funct3(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000: return alt ? cpu_pkg::alu_sub : cpu_pkg::alu_add;
      3'b001: return cpu_pkg::alu_sll;
      3'b010: return cpu_pkg::alu_slt;
      3'b011: return cpu_pkg::alu_sltu;
      3'b100: return cpu_pkg::alu_xor;
      3'b101: return alt ? cpu_pkg::alu_sra : cpu_pkg::alu_srl;
      3'b110: return cpu_pkg::alu_or;
      default: return cpu_pkg::alu_and;
    endcase
  endfunction

  always_comb begin
    decoder_out = '0;
    decoder_out.rs1 = instr[19:15];
    decoder_out.rs2 = instr[24:20];
    decoder_out.rd = instr[11:7];
    decoder_out.alu_op = cpu_pkg::alu_add;
    decoder_out.branch_op = cpu_pkg::br_none;
    case (opcode)
      cpu_pkg::op_lui: begin
        decoder_out.imm = {instr[31:12], 12'b0};
        decoder_out.alu_op = cpu_pkg::alu_pass_b;
        decoder_out.use_imm = 1'b1;
        decoder_out.write_rd = 1'b1;
      end
      cpu_pkg::op_jal: begin
        decoder_out.imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
        decoder_out.branch_op = cpu_pkg::br_jal;
        decoder_out.use_pc = 1'b1;
        decoder_out.write_rd = 1'b1;
      end
      cpu_pkg::op_jalr: begin
        decoder_out.imm = {{20{instr[31]}}, instr[31:20]};
        decoder_out.branch_op = cpu_pkg::br_jalr;
        decoder_out.use_pc = 1'b1;
        decoder_out.write_rd = 1'b1;
      end
      cpu_pkg::op_branch: begin
        decoder_out.imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        case (funct3)
          3'b000: decoder_out.branch_op = cpu_pkg::br_beq;
          3'b001: decoder_out.branch_op = cpu_pkg::br_bne;
          3'b100: decoder_out.branch_op = cpu_pkg::br_blt;
          3'b101: decoder_out.branch_op = cpu_pkg::br_bge;
          3'b110: decoder_out.branch_op = cpu_pkg::br_bltu;
          3'b111: decoder_out.branch_op = cpu_pkg::br_bgeu;
          default: decoder_out.branch_op = cpu_pkg::br_none;
        endcase
      end
      cpu_pkg::op_load: begin
        decoder_out.imm = {{20{instr[31]}}, instr[31:20]};
        decoder_out.use_imm = 1'b1;
        decoder_out.load = funct3 == 3'b010;       // Word loads only
        decoder_out.write_rd = funct3 == 3'b010;
      end
      cpu_pkg::op_store: begin
        decoder_out.imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        decoder_out.use_imm = 1'b1;
        decoder_out.store = funct3 == 3'b010;
      end
      cpu_pkg::op_imm: begin
        decoder_out.imm = {{20{instr[31]}}, instr[31:20]};
        decoder_out.alu_op = alu_from_funct3(funct3, instr[30] && funct3 == 3'b101);
        decoder_out.use_imm = 1'b1;
        decoder_out.write_rd = 1'b1;
      end
      cpu_pkg::op_reg: begin
        decoder_out.alu_op = alu_from_funct3(funct3, instr[30]);
        decoder_out.write_rd = 1'b1;
      end
      default: decoder_out.write_rd = 1'b0;        // Anything else is a no-op
    endcase
  end

endmodule

//--- hw/alu.sv
module alu (
  input cpu_pkg::alu_in_type alu_in,
  output cpu_pkg::alu_out_type alu_out
);

  logic [4:0] shamt;
  logic lt_signed;
  logic lt_unsigned;

  assign shamt = alu_in.b[4:0];
  assign lt_signed = $signed(alu_in.a) < $signed(alu_in.b);
  assign lt_unsigned = alu_in.a < alu_in.b;

  always_comb begin
    case (alu_in.op)
      cpu_pkg::alu_add: alu_out.result = alu_in.a + alu_in.b;
      cpu_pkg::alu_sub: alu_out.result = alu_in.a - alu_in.b;
      cpu_pkg::alu_and: alu_out.result = alu_in.a & alu_in.b;
      cpu_pkg::alu_or: alu_out.result = alu_in.a | alu_in.b;
      cpu_pkg::alu_xor: alu_out.result = alu_in.a ^ alu_in.b;
      cpu_pkg::alu_slt: alu_out.result = {31'b0, lt_signed};
      cpu_pkg::alu_sltu: alu_out.result = {31'b0, lt_unsigned};
      cpu_pkg::alu_sll: alu_out.result = alu_in.a << shamt;
      cpu_pkg::alu_srl: alu_out.result = alu_in.a >> shamt;
      cpu_pkg::alu_sra: alu_out.result = $signed(alu_in.a) >>> shamt;
      cpu_pkg::alu_pass_b: alu_out.result = alu_in.b;   // LUI
      default: alu_out.result = '0;
    endcase
  end

endmodule

//--- hw/bcu.sv
module bcu (
  input cpu_pkg::bcu_in_type bcu_in,
  output cpu_pkg::bcu_out_type bcu_out
);

  logic eq;
  logic lt;
  logic ltu;

  assign eq = bcu_in.a == bcu_in.b;
  assign lt = $signed(bcu_in.a) < $signed(bcu_in.b);
  assign ltu = bcu_in.a < bcu_in.b;

  always_comb begin
    case (bcu_in.branch_op)
      cpu_pkg::br_beq: bcu_out.taken = eq;
      cpu_pkg::br_bne: bcu_out.taken = !eq;
      cpu_pkg::br_blt: bcu_out.taken = lt;
      cpu_pkg::br_bge: bcu_out.taken = !lt;
      cpu_pkg::br_bltu: bcu_out.taken = ltu;
      cpu_pkg::br_bgeu: bcu_out.taken = !ltu;
      cpu_pkg::br_jal, cpu_pkg::br_jalr: bcu_out.taken = 1'b1;
      default: bcu_out.taken = 1'b0;
    endcase
    if (bcu_in.branch_op == cpu_pkg::br_jalr) begin
      bcu_out.target = (bcu_in.a + bcu_in.imm) & ~32'd1;
    end else begin
      bcu_out.target = bcu_in.pc + bcu_in.imm;
    end
  end

endmodule

//--- hw/register.sv
module register (
  input logic clock,
  input logic rst_n,
  input cpu_pkg::reg_addr_t raddr1,
  input cpu_pkg::reg_addr_t raddr2,
  output cpu_pkg::word_t rdata1,
  output cpu_pkg::word_t rdata2,
  input logic we,
  input cpu_pkg::reg_addr_t waddr,
  input cpu_pkg::word_t wdata
);

  cpu_pkg::word_t regs [32];

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && waddr != '0) begin
      regs[waddr] <= wdata;                      // x0 is never written
    end
  end

  // A write in this cycle shows up on the read port at once
  assign rdata1 = (raddr1 == '0) ? '0 :
                  (we && waddr == raddr1) ? wdata : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 :
                  (we && waddr == raddr2) ? wdata : regs[raddr2];

endmodule

//--- hw/fetch_stage.sv
module fetch_stage #(
  parameter cpu_pkg::word_t reset_pc = '0
) (
  input logic clock,
  input logic rst_n,
  input logic stall,
  input cpu_pkg::redirect_type redirect,
  input cpu_pkg::mem_out_type imem_out,
  output cpu_pkg::mem_in_type imem_in,
  output cpu_pkg::fetch_out_type fetch_out
);

  typedef enum logic [1:0] {
    idle,
    request,
    discard
  } fetch_state_t;

  fetch_state_t state;
  cpu_pkg::word_t pc;
  cpu_pkg::word_t target_pc;
  logic take;

  assign take = !fetch_out.valid || !stall;      // Fetch register is free or drains now

  assign imem_in.mem_valid = state != idle;
  assign imem_in.mem_instr = 1'b1;
  assign imem_in.mem_addr = pc;
  assign imem_in.mem_wdata = '0;
  assign imem_in.mem_write = 1'b0;

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      state <= idle;
      pc <= reset_pc;
      fetch_out.valid <= 1'b0;
    end else begin
      if (!stall) begin
        fetch_out.valid <= 1'b0;
      end
      case (state)
        idle: state <= request;
        request: begin
          if (redirect.valid) begin
            if (imem_out.mem_ready) begin
              pc <= redirect.target;
            end else begin
              target_pc <= redirect.target;      // Let the stale fetch finish first
              state <= discard;
            end
          end else if (imem_out.mem_ready && take) begin
            fetch_out.valid <= 1'b1;
            fetch_out.pc <= pc;
            fetch_out.instr <= imem_out.mem_rdata;
            pc <= pc + 32'd4;
          end
          // A response that finds the register full is dropped and fetched again
        end
        discard: begin
          if (imem_out.mem_ready) begin
            pc <= target_pc;
            state <= request;
          end
        end
        default: state <= idle;
      endcase
    end
  end

endmodule

//--- hw/execute_stage.sv
module execute_stage (
  input logic clock,
  input logic rst_n,
  input cpu_pkg::fetch_out_type fetch_out,
  input cpu_pkg::memory_fwd_type memory_fwd,
  input logic mem_busy,
  output cpu_pkg::reg_addr_t raddr1,
  output cpu_pkg::reg_addr_t raddr2,
  input cpu_pkg::word_t rdata1,
  input cpu_pkg::word_t rdata2,
  output logic stall,
  output cpu_pkg::redirect_type redirect,
  output cpu_pkg::execute_out_type execute_out
);

  cpu_pkg::decoder_out_type decoder_out;
  cpu_pkg::alu_in_type alu_in;
  cpu_pkg::alu_out_type alu_out;
  cpu_pkg::bcu_in_type bcu_in;
  cpu_pkg::bcu_out_type bcu_out;
  cpu_pkg::word_t op1;
  cpu_pkg::word_t op2;
  logic fwd1;
  logic fwd2;
  logic load_use;

  decoder decoder_comp (
    .instr(fetch_out.instr),
    .decoder_out(decoder_out)
  );

  alu alu_comp (
    .alu_in(alu_in),
    .alu_out(alu_out)
  );

  bcu bcu_comp (
    .bcu_in(bcu_in),
    .bcu_out(bcu_out)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Operands and hazards
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign raddr1 = decoder_out.rs1;
  assign raddr2 = decoder_out.rs2;

  assign fwd1 = memory_fwd.valid && memory_fwd.rd != '0 && memory_fwd.rd == decoder_out.rs1;
  assign fwd2 = memory_fwd.valid && memory_fwd.rd != '0 && memory_fwd.rd == decoder_out.rs2;
  assign op1 = fwd1 ? memory_fwd.value : rdata1;
  assign op2 = fwd2 ? memory_fwd.value : rdata2;

  // Load data lands in the register file one cycle after the load completes
  assign load_use = execute_out.valid && execute_out.load && execute_out.rd != '0 &&
                    (execute_out.rd == decoder_out.rs1 || execute_out.rd == decoder_out.rs2);
  assign stall = mem_busy || (fetch_out.valid && load_use);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Units
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign alu_in.a = decoder_out.use_pc ? fetch_out.pc : op1;
  assign alu_in.b = decoder_out.use_pc ? 32'd4 : (decoder_out.use_imm ? decoder_out.imm : op2);
  assign alu_in.op = decoder_out.alu_op;

  assign bcu_in.a = op1;
  assign bcu_in.b = op2;
  assign bcu_in.pc = fetch_out.pc;
  assign bcu_in.imm = decoder_out.imm;
  assign bcu_in.branch_op = decoder_out.branch_op;

  assign redirect.valid = fetch_out.valid && !stall && bcu_out.taken;
  assign redirect.target = bcu_out.target;

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      execute_out.valid <= 1'b0;
    end else if (!mem_busy) begin
      execute_out.valid <= fetch_out.valid && !stall;   // Bubble on a load-use stall
      execute_out.result <= alu_out.result;
      execute_out.store_data <= op2;
      execute_out.rd <= decoder_out.rd;
      execute_out.write_rd <= decoder_out.write_rd;
      execute_out.load <= decoder_out.load;
      execute_out.store <= decoder_out.store;
    end
  end

endmodule

//--- hw/memory_stage.sv
module memory_stage (
  input logic clock,
  input logic rst_n,
  input cpu_pkg::execute_out_type execute_out,
  input cpu_pkg::mem_out_type dmem_out,
  output cpu_pkg::mem_in_type dmem_in,
  output logic busy,
  output logic we,
  output cpu_pkg::reg_addr_t waddr,
  output cpu_pkg::word_t wdata,
  output cpu_pkg::memory_fwd_type memory_fwd
);

  logic mem_op;
  logic done;
  logic writing;

  assign mem_op = execute_out.valid && (execute_out.load || execute_out.store);
  assign done = dmem_in.mem_valid && dmem_out.mem_ready;
  assign busy = mem_op && !done;                 // Held from valid up to the ready edge

  // The request is registered, so it stays stable until ready
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      dmem_in.mem_valid <= 1'b0;
    end else if (done) begin
      dmem_in.mem_valid <= 1'b0;
    end else if (mem_op && !dmem_in.mem_valid) begin
      dmem_in.mem_valid <= 1'b1;
      dmem_in.mem_instr <= 1'b0;
      dmem_in.mem_addr <= execute_out.result;
      dmem_in.mem_wdata <= execute_out.store_data;
      dmem_in.mem_write <= execute_out.store;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Writeback
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign writing = execute_out.valid && execute_out.write_rd && (!execute_out.load || done);

  assign we = writing;
  assign waddr = execute_out.rd;
  assign wdata = execute_out.load ? dmem_out.mem_rdata : execute_out.result;

  assign memory_fwd.valid = writing;             // Only a final value is forwarded
  assign memory_fwd.rd = execute_out.rd;
  assign memory_fwd.value = wdata;

endmodule

//--- hw/cpu.sv
module cpu #(
  parameter cpu_pkg::word_t reset_pc = '0
) (
  input logic clock,
  input logic rst_n,
  input cpu_pkg::mem_out_type imem_out,
  input cpu_pkg::mem_out_type dmem_out,
  output cpu_pkg::mem_in_type imem_in,
  output cpu_pkg::mem_in_type dmem_in
);

  cpu_pkg::fetch_out_type fetch_out;
  cpu_pkg::execute_out_type execute_out;
  cpu_pkg::redirect_type redirect;
  cpu_pkg::memory_fwd_type memory_fwd;
  cpu_pkg::reg_addr_t raddr1;
  cpu_pkg::reg_addr_t raddr2;
  cpu_pkg::word_t rdata1;
  cpu_pkg::word_t rdata2;
  cpu_pkg::reg_addr_t waddr;
  cpu_pkg::word_t wdata;
  logic we;
  logic stall;
  logic mem_busy;

  fetch_stage #(
    .reset_pc(reset_pc)
  ) fetch_stage_comp (
    .clock(clock),
    .rst_n(rst_n),
    .stall(stall),
    .redirect(redirect),
    .imem_out(imem_out),
    .imem_in(imem_in),
    .fetch_out(fetch_out)
  );

  execute_stage execute_stage_comp (
    .clock(clock),
    .rst_n(rst_n),
    .fetch_out(fetch_out),
    .memory_fwd(memory_fwd),
    .mem_busy(mem_busy),
    .raddr1(raddr1),
    .raddr2(raddr2),
    .rdata1(rdata1),
    .rdata2(rdata2),
    .stall(stall),
    .redirect(redirect),
    .execute_out(execute_out)
  );

  memory_stage memory_stage_comp (
    .clock(clock),
    .rst_n(rst_n),
    .execute_out(execute_out),
    .dmem_out(dmem_out),
    .dmem_in(dmem_in),
    .busy(mem_busy),
    .we(we),
    .waddr(waddr),
    .wdata(wdata),
    .memory_fwd(memory_fwd)
  );

  register register_comp (
    .clock(clock),
    .rst_n(rst_n),
    .raddr1(raddr1),
    .raddr2(raddr2),
    .rdata1(rdata1),
    .rdata2(rdata2),
    .we(we),
    .waddr(waddr),
    .wdata(wdata)
  );

endmodule

//--- bench/cpu_sva.sv
module cpu_sva (
  input logic clock,
  input logic rst_n,
  input cpu_pkg::mem_in_type imem_in,
  input cpu_pkg::mem_out_type imem_out,
  input cpu_pkg::mem_in_type dmem_in,
  input cpu_pkg::mem_out_type dmem_out
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Request stays put until ready
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  imem_hold: assert property (@(posedge clock) disable iff (!rst_n)
    imem_in.mem_valid && !imem_out.mem_ready |=> imem_in.mem_valid &&
    $stable(imem_in.mem_addr))
    else $error("imem request changed before ready");

  dmem_hold: assert property (@(posedge clock) disable iff (!rst_n)
    dmem_in.mem_valid && !dmem_out.mem_ready |=> dmem_in.mem_valid &&
    $stable(dmem_in.mem_addr) && $stable(dmem_in.mem_wdata) && $stable(dmem_in.mem_write))
    else $error("dmem request changed before ready");

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Ready only with valid, and quiet ports in reset
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  imem_ready_valid: assert property (@(posedge clock) disable iff (!rst_n)
    imem_out.mem_ready |-> imem_in.mem_valid)
    else $error("imem ready without valid");

  dmem_ready_valid: assert property (@(posedge clock) disable iff (!rst_n)
    dmem_out.mem_ready |-> dmem_in.mem_valid)
    else $error("dmem ready without valid");

  reset_quiet: assert property (@(posedge clock)
    !rst_n |=> !imem_in.mem_valid && !dmem_in.mem_valid)
    else $error("memory request during reset");

endmodule

bind cpu cpu_sva sva_comp (
  .clock(clock),
  .rst_n(rst_n),
  .imem_in(imem_in),
  .imem_out(imem_out),
  .dmem_in(dmem_in),
  .dmem_out(dmem_out)
);

//--- bench/cpu_tb.sv
module cpu_tb;

  localparam int max_delay = 3;                  // Memory answers after 0 to 3 cycles

  logic clock;
  logic rst_n;
  cpu_pkg::mem_in_type imem_in;
  cpu_pkg::mem_in_type dmem_in;
  cpu_pkg::mem_out_type imem_out;
  cpu_pkg::mem_out_type dmem_out;

  cpu_pkg::word_t trace [256];
  cpu_pkg::instr_t program_words [64];
  cpu_pkg::word_t expected_addr [32];
  cpu_pkg::word_t expected_data [32];
  cpu_pkg::word_t data_mem [cpu_pkg::word_t];
  cpu_pkg::word_t rng_state;
  int prog_count;
  int store_count;
  int store_index;
  int passed;
  int failed;
  int cycles;
  int limit;
  int imem_wait;
  int dmem_wait;
  bit imem_armed;
  bit dmem_armed;
  logic finished;

  cpu #(
    .reset_pc(32'h0)
  ) uut (
    .clock(clock),
    .rst_n(rst_n),
    .imem_out(imem_out),
    .dmem_out(dmem_out),
    .imem_in(imem_in),
    .dmem_in(dmem_in)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  function automatic cpu_pkg::word_t next_random(input cpu_pkg::word_t s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check_fetch(input cpu_pkg::word_t addr);
    if (addr[1:0] != 2'b00 || addr >= cpu_pkg::word_t'(prog_count * 4)) begin
      $display("fetch outside the program at address %h", addr);
      failed++;
    end
  endtask

  task automatic check_request_kind(input cpu_pkg::mem_in_type req, input logic fetch);
    if (req.mem_instr !== fetch) begin
      $display("mismatch mem_instr: got %h expected %h", req.mem_instr, fetch);
      failed++;
    end
    if (fetch && req.mem_write !== 1'b0) begin
      $display("mismatch imem mem_write: got %h expected %h", req.mem_write, 1'b0);
      failed++;
    end
  endtask

  task automatic check_store(input cpu_pkg::word_t addr, input cpu_pkg::word_t data);
    bit ok;
    ok = 1'b1;
    if (store_index >= store_count) begin
      $display("store to %h with data %h is beyond the expected list", addr, data);
      failed++;
    end else begin
      if (addr !== expected_addr[store_index]) begin
        $display("mismatch store_addr: got %h expected %h", addr, expected_addr[store_index]);
        ok = 1'b0;
      end
      if (data !== expected_data[store_index]) begin
        $display("mismatch store_data: got %h expected %h", data, expected_data[store_index]);
        ok = 1'b0;
      end
      if (ok) begin
        passed++;
        $display("store %0d to %h: ok", store_index, addr);
      end else begin
        failed++;
        $display("store %0d: failed", store_index);
      end
    end
    store_index++;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Instruction and data memory models
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always @(posedge clock) begin
    if (!rst_n) begin
      imem_out <= '0;
      dmem_out <= '0;
      imem_armed = 1'b0;
      dmem_armed = 1'b0;
    end else begin
      if (imem_out.mem_ready) begin
        imem_out.mem_ready <= 1'b0;              // Transfer completed at this edge
      end else if (imem_in.mem_valid) begin
        if (!imem_armed) begin
          rng_state = next_random(rng_state);
          imem_wait = int'(rng_state[31:30]);
          imem_armed = 1'b1;
        end
        if (imem_wait == 0) begin
          check_fetch(imem_in.mem_addr);
          check_request_kind(imem_in, 1'b1);
          imem_out.mem_ready <= 1'b1;
          imem_out.mem_rdata <= program_words[imem_in.mem_addr[7:2]];
          imem_armed = 1'b0;
        end else begin
          imem_wait--;
        end
      end
      if (dmem_out.mem_ready) begin
        dmem_out.mem_ready <= 1'b0;
      end else if (dmem_in.mem_valid) begin
        if (!dmem_armed) begin
          rng_state = next_random(rng_state);
          dmem_wait = int'(rng_state[31:30]);
          dmem_armed = 1'b1;
        end
        if (dmem_wait == 0) begin
          check_request_kind(dmem_in, 1'b0);
          dmem_out.mem_ready <= 1'b1;
          dmem_armed = 1'b0;
          if (dmem_in.mem_write) begin
            check_store(dmem_in.mem_addr, dmem_in.mem_wdata);
            data_mem[dmem_in.mem_addr] = dmem_in.mem_wdata;
            dmem_out.mem_rdata <= '0;
            if (dmem_in.mem_addr == 32'hFFFC) begin
              finished <= 1'b1;                  // Last store of the program
            end
          end else if (data_mem.exists(dmem_in.mem_addr)) begin
            dmem_out.mem_rdata <= data_mem[dmem_in.mem_addr];
          end else begin
            dmem_out.mem_rdata <= dmem_in.mem_addr ^ 32'hA5A5_5A5A;
          end
        end else begin
          dmem_wait--;
        end
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Trace loading, reset and run control
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    rst_n = 1'b0;
    imem_out = '0;
    dmem_out = '0;
    finished = 1'b0;
    rng_state = 32'h788b_64f5;
    store_index = 0;
    passed = 0;
    failed = 0;
    $readmemh("bench/program_trace.txt", trace);
    prog_count = int'(trace[0]);
    for (int i = 0; i < 64; i++) begin
      program_words[i] = (i < prog_count) ? trace[1 + i] : 32'h0000_0013;
    end
    store_count = int'(trace[1 + prog_count]);
    for (int j = 0; j < store_count; j++) begin
      expected_addr[j] = trace[2 + prog_count + 2 * j];
      expected_data[j] = trace[3 + prog_count + 2 * j];
    end
    limit = 40 * prog_count * (max_delay + 1);
    repeat (5) @(posedge clock);
    rst_n <= 1'b1;
    cycles = 0;
    while (!finished && cycles < limit) begin
      @(posedge clock);
      cycles++;
    end
    if (!finished) begin
      $display("timeout after %0d cycles without the final store", cycles);
      failed++;
    end
    if (store_index != store_count) begin
      $display("saw %0d stores but the trace expects %0d", store_index, store_count);
      failed++;
    end
    $display("stores checked %0d, passed %0d, failed %0d", store_index, passed, failed);
    if (failed == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- list.f
hw/cpu_pkg.sv
hw/decoder.sv
hw/alu.sv
hw/bcu.sv
hw/register.sv
hw/fetch_stage.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/cpu.sv
bench/cpu_sva.sv
bench/cpu_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the cpu testbench with Verilator, from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module cpu_tb \
  -f list.f \
  -o cpu_tb_sim

./obj_dir/cpu_tb_sim 2>&1 | tee sim.log

if grep -q "^Regression passed$" sim.log; then
  echo "run.sh: simulation passed"
  exit 0
else
  echo "run.sh: simulation failed"
  exit 1
fi

//--- bench/program_trace.txt
// Line 1: program word count, then the program words, four per line
// Then the store count, then one expected store per line as address and data
00000028
123450B7 67808093 10000513 00152023
FFB00113 40115193 01C15213 004182B3
00552223 00412333 004133B3 0020C433
406404B3 00952423 006215B3 0055F633
00C52623 00052683 00168713 00E52823
00730463 00731463 00152A23 008007EF
00152C23 00F52A23 01078867 00152E23
01052C23 00414463 02152023 00417463
02152223 00416463 00415463 000108B7
FE38AE23 0000006F 00000013 00000013
00000008
00000100 12345678
00000104 0000000C
00000108 EDCBA982
0000010C 0000000C
00000110 12345679
00000114 00000060
00000118 0000006C
0000FFFC FFFFFFFD
